//--- project.f
+incdir+sim
verilog/accel_net_pkg.sv
verilog/accel_map_pkg.sv
verilog/accel_rx_fifo.sv
verilog/accel_cfg_regs.sv
verilog/accel_credit_counter.sv
verilog/accel_packet_issue.sv
verilog/accel_tile.sv
sim/tb_accel_tile.sv

//--- sim/tb_accel_model.svh
`ifndef TB_ACCEL_MODEL_SVH
`define TB_ACCEL_MODEL_SVH

// requests held by the tile, oldest first
accel_net_pkg::rx_req_s     model_req_q[$];
// packets still owed to the link, oldest first
accel_net_pkg::net_packet_s model_pkt_q[$];
accel_map_pkg::cfg_s        model_cfg;
int                         model_credits;
bit                         model_out_v;
// packet for the current head already queued
bit                         model_head_queued;

task automatic model_reset();
   model_req_q.delete();
   model_pkt_q.delete();
   model_cfg         = '0;
   model_credits     = 4;
   model_out_v       = 1'b0;
   model_head_queued = 1'b0;
endtask

// a forward at the head is offered only while a credit is left
task automatic model_offer();
   accel_net_pkg::net_packet_s pkt;
   model_out_v = (model_req_q.size() > 0) && (model_req_q[0].addr[1:0] == 2'd2) &&
                 (model_credits > 0);
   if (model_out_v && !model_head_queued)
   begin
      // store to the configured target, replies back to this tile
      pkt = '{addr: model_cfg.out_addr, data: model_req_q[0].data, op_ex: 4'hf,
              op: accel_net_pkg::net_op_store, y_cord: model_cfg.dest_y,
              x_cord: model_cfg.dest_x, src_y_cord: my_y_i, src_x_cord: my_x_i};
      model_pkt_q.push_back(pkt);
      model_head_queued = 1'b1;
   end
endtask

// state change on the coming clock edge
task automatic model_advance(input logic in_v, input accel_net_pkg::rx_req_s in_req,
                             input logic out_ready, input logic credit_ret);
   bit accept;
   bit sent;
   accept = in_v && (model_req_q.size() < 4);
   sent   = 1'b0;
   if (model_req_q.size() > 0)
   begin
      case (model_req_q[0].addr[1:0])
         // out address and destination take the low data bits
         2'd0:    model_cfg.out_addr = model_req_q[0].data[11:0];
         2'd1:    {model_cfg.dest_y, model_cfg.dest_x} = model_req_q[0].data[6:0];
         2'd2:    sent = model_out_v && out_ready;
         default: ;
      endcase
      // only a waiting forward stays at the head
      if (model_req_q[0].addr[1:0] != 2'd2 || sent)
      begin
         void'(model_req_q.pop_front());
         model_head_queued = 1'b0;
      end
   end
   if (sent)
      void'(model_pkt_q.pop_front());
   // send and return on one edge cancel out
   if (sent && !credit_ret)
      model_credits--;
   else if (!sent && credit_ret && model_credits < 4)
      model_credits++;
   if (accept)
      model_req_q.push_back(in_req);
endtask

`endif

//--- sim/tb_accel_tile.sv
`default_nettype none

module tb_accel_tile;

   logic                                      clk_i;
   logic                                      rst_n_i;
   logic                                      in_v_i;
   accel_net_pkg::rx_req_s                    in_req_i;
   logic                                      in_ready_o;
   logic                                      out_v_o;
   accel_net_pkg::net_packet_s                out_packet_o;
   logic                                      out_ready_i;
   logic                                      link_credit_i;
   logic [accel_map_pkg::credit_width_lp-1:0] out_credits_o;
   logic [accel_net_pkg::x_cord_width_lp-1:0] my_x_i;
   logic [accel_net_pkg::y_cord_width_lp-1:0] my_y_i;

   int                         errors;
   int                         tests_failed;
   int                         sent_count;
   // forwards taken in by the queue
   int                         fwd_count;
   // link behaviour in percent per cycle
   int                         ready_pct;
   int                         credit_pct;
   bit                         checking;
   bit                         held_v;
   accel_net_pkg::net_packet_s held_pkt;

   `include "tb_accel_model.svh"

   accel_tile DUT (.*);

   always #20 clk_i = ~clk_i;

   // link side drives ready and credit pulses at random
   always @(posedge clk_i)
   begin
      out_ready_i   <= ($urandom_range(99) < ready_pct);
      link_credit_i <= ($urandom_range(99) < credit_pct);
   end

   task automatic log_mismatch(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
   endtask

   task automatic log_timeout(input string what);
      $display("timeout while waiting for %s", what);
      errors++;
   endtask

   // compare against the model at mid cycle, then step the model
   always @(negedge clk_i)
   begin
      if (checking)
      begin
         model_offer();
         assert (in_ready_o == (model_req_q.size() < 4))
         else log_mismatch("in_ready_o", in_ready_o, model_req_q.size() < 4);
         assert (out_credits_o == model_credits && out_credits_o <= 4)
         else log_mismatch("out_credits_o", out_credits_o, model_credits);
         assert (out_v_o == model_out_v)
         else log_mismatch("out_v_o", out_v_o, model_out_v);
         assert (!model_out_v || out_packet_o == model_pkt_q[0])
         else log_mismatch("out_packet_o", out_packet_o, model_pkt_q[0]);
         // a stalled packet must not change
         assert (!(held_v && out_v_o) || out_packet_o == held_pkt)
         else log_mismatch("out_packet_o", out_packet_o, held_pkt);
         held_v   = out_v_o && !out_ready_i;
         held_pkt = out_packet_o;
         if (out_v_o && out_ready_i)
            sent_count++;
         // forward accepted on the coming edge
         if (in_v_i && in_ready_o && in_req_i.addr[1:0] == 2'd2)
            fwd_count++;
         model_advance(in_v_i, in_req_i, out_ready_i, link_credit_i);
      end
   end

   // mostly forwards, the rest spread over the register map
   function automatic accel_net_pkg::rx_req_s random_req();
      accel_net_pkg::rx_req_s req;
      int                     pick;
      pick          = $urandom_range(9);
      req.addr      = 12'($urandom);
      req.addr[1:0] = (pick < 6) ? 2'd2 : 2'(pick - 6);
      req.data      = $urandom;
      req.mask      = 4'($urandom);
      return req;
   endfunction

   // hold one write until the queue takes it
   task automatic write_req(input logic [1:0] sel, input logic [31:0] data);
      accel_net_pkg::rx_req_s req;
      int                     waited;
      req           = random_req();
      req.addr[1:0] = sel;
      req.data      = data;
      waited        = 0;
      @(posedge clk_i);
      in_v_i   <= 1'b1;
      in_req_i <= req;
      @(negedge clk_i);
      while (!in_ready_o && waited < 100)
      begin
         @(negedge clk_i);
         waited++;
      end
      assert (in_ready_o) else log_timeout("in_ready_o");
      @(posedge clk_i);
      in_v_i <= 1'b0;
   endtask

   task automatic set_link(input int ready, input int credit);
      @(negedge clk_i);
      ready_pct  = ready;
      credit_pct = credit;
   endtask

   // empty queue and all credits back
   task automatic drain_tile();
      int waited;
      waited = 0;
      set_link(100, 50);
      while ((model_req_q.size() > 0 || model_credits < 4) && waited < 500)
      begin
         @(posedge clk_i);
         waited++;
      end
      assert (waited < 500) else log_timeout("queue drain");
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (errors == errs_before)
         $display("test %s passed", name);
      else
      begin
         $display("test %s failed with %0d errors", name, errors - errs_before);
         tests_failed++;
      end
   endtask

   initial
   begin
      int mark;
      void'($urandom(7912));
      clk_i         = 1'b0;
      rst_n_i       = 1'b0;
      in_v_i        = 1'b0;
      in_req_i      = '0;
      out_ready_i   = 1'b0;
      link_credit_i = 1'b0;
      my_x_i        = 4'd5;
      my_y_i        = 3'd2;
      ready_pct     = 100;
      credit_pct    = 0;
      errors        = 0;
      tests_failed  = 0;
      sent_count    = 0;
      fwd_count     = 0;
      held_v        = 1'b0;
      checking      = 1'b0;
      model_reset();
      repeat (2) @(posedge clk_i);
      rst_n_i  <= 1'b1;
      checking = 1'b1;

      mark = errors;
      @(negedge clk_i);
      assert (!out_v_o) else log_mismatch("out_v_o", out_v_o, 0);
      assert (in_ready_o) else log_mismatch("in_ready_o", in_ready_o, 1);
      assert (out_credits_o == 4) else log_mismatch("out_credits_o", out_credits_o, 4);
      finish_test("reset", mark);

      // upper data bits of config writes are junk
      mark = errors;
      write_req(2'd0, 32'hdead_0a5c);
      write_req(2'd1, 32'hbeef_ff69);
      set_link(100, 100);
      repeat (3) write_req(2'd2, $urandom);
      write_req(2'd0, 32'h0000_0123);
      write_req(2'd1, {25'd0, 3'd1, 4'd14});
      repeat (3) write_req(2'd2, $urandom);
      drain_tile();
      finish_test("packet fields", mark);

      // no returns, so only four packets may leave
      mark       = errors;
      sent_count = 0;
      set_link(100, 0);
      repeat (6) write_req(2'd2, $urandom);
      repeat (10)
      begin
         @(negedge clk_i);
         assert (!out_v_o) else log_mismatch("out_v_o", out_v_o, 0);
      end
      @(posedge clk_i);
      assert (sent_count == 4) else log_mismatch("sent packets", sent_count, 4);
      drain_tile();
      assert (sent_count == 6) else log_mismatch("sent packets", sent_count, 6);
      finish_test("credit limit", mark);

      mark = errors;
      set_link(25, 30);
      repeat (8) write_req(2'd2, $urandom);
      drain_tile();
      finish_test("back-pressure", mark);

      // stalled forward at the head lets the queue fill
      mark = errors;
      set_link(0, 0);
      write_req(2'd2, $urandom);
      write_req(2'd3, $urandom);
      write_req(2'd2, $urandom);
      write_req(2'd3, $urandom);
      @(negedge clk_i);
      assert (!in_ready_o) else log_mismatch("in_ready_o", in_ready_o, 0);
      set_link(100, 100);
      write_req(2'd2, $urandom);
      repeat (3) write_req(2'd3, $urandom);
      write_req(2'd2, $urandom);
      drain_tile();
      finish_test("discard and full queue", mark);

      // every accepted forward leaves exactly once
      mark       = errors;
      sent_count = 0;
      fwd_count  = 0;
      set_link(70, 40);
      repeat (600)
      begin
         @(posedge clk_i);
         in_v_i   <= ($urandom_range(99) < 60);
         in_req_i <= random_req();
      end
      @(posedge clk_i);
      in_v_i <= 1'b0;
      drain_tile();
      @(negedge clk_i);
      assert (sent_count == fwd_count)
      else log_mismatch("sent packets", sent_count, fwd_count);
      assert (out_credits_o == 4) else log_mismatch("out_credits_o", out_credits_o, 4);
      finish_test("random run", mark);

      $display("tests run 6, tests failed %0d, checks failed %0d", tests_failed, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/accel_cfg_regs.sv
`default_nettype none

module accel_cfg_regs
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   head_v_i,
   input  accel_net_pkg::rx_req_s head_req_i,
   output logic                   cfg_take_o,
   output accel_map_pkg::cfg_s    cfg_o
);

   accel_map_pkg::accel_reg_e sel;
   accel_map_pkg::cfg_s       cfg_r;
   logic                      addr_we;
   logic                      dest_we;

   // register select sits in the low address bits
   assign sel = accel_map_pkg::accel_reg_e'(
                   head_req_i.addr[accel_map_pkg::reg_sel_width_lp-1:0]);

   // write enables for the two configuration registers
   always_comb
   begin
      addr_we = 1'b0;
      dest_we = 1'b0;
      if (head_v_i)
      begin
         case (sel)
            accel_map_pkg::reg_out_addr: addr_we = 1'b1;
            accel_map_pkg::reg_out_dest: dest_we = 1'b1;
            default:                     ;
         endcase
      end
   end

   // config writes always complete in one cycle
   assign cfg_take_o = addr_we | dest_we;

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         cfg_r <= '0;
      else
      begin
         if (addr_we)
            cfg_r.out_addr <= head_req_i.data[accel_net_pkg::addr_width_lp-1:0];
         // destination arrives packed as {y, x}
         if (dest_we)
            {cfg_r.dest_y, cfg_r.dest_x} <=
               head_req_i.data[accel_map_pkg::dest_width_lp-1:0];
      end
   end

   assign cfg_o = cfg_r;

endmodule

`default_nettype wire

//--- verilog/accel_credit_counter.sv
`default_nettype none

module accel_credit_counter
(
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,
   input  logic                                      sent_i,
   input  logic                                      credit_return_i,
   output logic [accel_map_pkg::credit_width_lp-1:0] credits_o
);

   logic [accel_map_pkg::credit_width_lp-1:0] credits_r;
   logic                                      at_max;
   logic                                      at_zero;

   // saturation limits
   assign at_max  = (credits_r == accel_map_pkg::credit_width_lp'(
                                     accel_map_pkg::max_out_credits_lp));
   assign at_zero = (credits_r == '0);

   // starts full, each sent packet borrows one credit
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         credits_r <= accel_map_pkg::credit_width_lp'(
                         accel_map_pkg::max_out_credits_lp);
      else
      begin
         case ({sent_i, credit_return_i})
            // send only
            2'b10:
            begin
               if (!at_zero)
                  credits_r <= credits_r - 1'b1;
            end
            // return only, clamp at the limit
            2'b01:
            begin
               if (!at_max)
                  credits_r <= credits_r + 1'b1;
            end
            // both or neither leave the count alone
            default: credits_r <= credits_r;
         endcase
      end
   end

   // visible to the processor for fences
   assign credits_o = credits_r;

endmodule

`default_nettype wire

//--- verilog/accel_map_pkg.sv
`default_nettype none

package accel_map_pkg;

   // number of low address bits that select a tile register
   localparam int reg_sel_width_lp = 2;

   // decoded register map of the tile
   typedef enum logic [reg_sel_width_lp-1:0]
   {
      reg_out_addr = 2'd0,
      reg_out_dest = 2'd1,
      reg_forward  = 2'd2,
      reg_discard  = 2'd3
   } accel_reg_e;

   // destination is written as one {y, x} field in the data word
   localparam int dest_width_lp =
      accel_net_pkg::y_cord_width_lp + accel_net_pkg::x_cord_width_lp;

   // configuration applied to every outgoing packet
   typedef struct packed
   {
      logic [accel_net_pkg::addr_width_lp-1:0]   out_addr;
      logic [accel_net_pkg::y_cord_width_lp-1:0] dest_y;
      logic [accel_net_pkg::x_cord_width_lp-1:0] dest_x;
   } cfg_s;

   // receive queue sizing
   localparam int rx_fifo_els_lp     = 4;
   localparam int rx_ptr_width_lp    = $clog2(rx_fifo_els_lp);
   localparam int rx_count_width_lp  = $clog2(rx_fifo_els_lp + 1);

   // outstanding packet limit and the width of its counter
   localparam int max_out_credits_lp = 4;
   localparam int credit_width_lp    = 3;

endpackage

`default_nettype wire

//--- verilog/accel_net_pkg.sv
`default_nettype none

package accel_net_pkg;

   // network address and data word sizes
   localparam int addr_width_lp = 12;
   localparam int data_width_lp = 32;

   // one mask bit per byte of the data word
   localparam int mask_width_lp = data_width_lp / 8;

   // mesh coordinate widths
   localparam int x_cord_width_lp = 4;
   localparam int y_cord_width_lp = 3;

   // packet opcodes
   // the tile itself only ever issues stores
   typedef enum logic [1:0]
   {
      net_op_load     = 2'b00,
      net_op_store    = 2'b01,
      net_op_reserved = 2'b10
   } net_op_e;

   // outgoing packet, destination first then return coordinates
   typedef struct packed
   {
      logic [addr_width_lp-1:0]   addr;
      logic [data_width_lp-1:0]   data;
      // byte enables for the store
      logic [mask_width_lp-1:0]   op_ex;
      net_op_e                    op;
      logic [y_cord_width_lp-1:0] y_cord;
      logic [x_cord_width_lp-1:0] x_cord;
      // where replies for this packet should go
      logic [y_cord_width_lp-1:0] src_y_cord;
      logic [x_cord_width_lp-1:0] src_x_cord;
   } net_packet_s;

   // remote write as it arrives over the link
   typedef struct packed
   {
      logic [addr_width_lp-1:0] addr;
      logic [data_width_lp-1:0] data;
      logic [mask_width_lp-1:0] mask;
   } rx_req_s;

endpackage

`default_nettype wire

//--- verilog/accel_packet_issue.sv
`default_nettype none

module accel_packet_issue
(
   input  logic                                       head_v_i,
   input  accel_net_pkg::rx_req_s                     head_req_i,
   input  accel_map_pkg::cfg_s                        cfg_i,
   input  logic                                       cfg_take_i,
   input  logic [accel_map_pkg::credit_width_lp-1:0]  credits_i,
   input  logic                                       out_ready_i,
   input  logic [accel_net_pkg::x_cord_width_lp-1:0]  my_x_i,
   input  logic [accel_net_pkg::y_cord_width_lp-1:0]  my_y_i,
   output logic                                       out_v_o,
   output accel_net_pkg::net_packet_s                 out_packet_o,
   output logic                                       sent_o,
   output logic                                       pop_o
);

   accel_map_pkg::accel_reg_e sel;
   logic                      fwd_head;
   logic                      discard_head;
   logic                      have_credit;

   // same decode as the config block, on the same head entry
   assign sel = accel_map_pkg::accel_reg_e'(
                   head_req_i.addr[accel_map_pkg::reg_sel_width_lp-1:0]);

   assign fwd_head     = head_v_i & (sel == accel_map_pkg::reg_forward);
   assign discard_head = head_v_i & (sel == accel_map_pkg::reg_discard);
   assign have_credit  = (credits_i != '0);

   // forward only while a credit is free
   // otherwise the entry waits at the head
   assign out_v_o = fwd_head & have_credit;

   // leaves the queue only once the link takes it
   assign sent_o = out_v_o & out_ready_i;

   // one pop for whichever consumer used the head this cycle
   // discard never waits, so address 3 cannot stall the queue
   assign pop_o = cfg_take_i | sent_o | discard_head;

   // packet fields come from config, head and tile position
   // stays steady under back-pressure since head and config hold
   always_comb
   begin
      out_packet_o.addr       = cfg_i.out_addr;
      out_packet_o.data       = head_req_i.data;
      // full word store
      out_packet_o.op_ex      = '1;
      out_packet_o.op         = accel_net_pkg::net_op_store;
      out_packet_o.y_cord     = cfg_i.dest_y;
      out_packet_o.x_cord     = cfg_i.dest_x;
      // replies come back to this tile
      out_packet_o.src_y_cord = my_y_i;
      out_packet_o.src_x_cord = my_x_i;
   end

endmodule

`default_nettype wire

//--- verilog/accel_rx_fifo.sv
`default_nettype none

module accel_rx_fifo
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  logic                   in_v_i,
   input  accel_net_pkg::rx_req_s in_req_i,
   output logic                   in_ready_o,
   input  logic                   pop_i,
   output logic                   head_v_o,
   output accel_net_pkg::rx_req_s head_req_o
);

   // entry storage, indexed by the two circular pointers
   accel_net_pkg::rx_req_s mem_r [accel_map_pkg::rx_fifo_els_lp];

   logic [accel_map_pkg::rx_ptr_width_lp-1:0]   wr_ptr_r;
   logic [accel_map_pkg::rx_ptr_width_lp-1:0]   rd_ptr_r;
   logic [accel_map_pkg::rx_count_width_lp-1:0] count_r;

   logic push;
   logic pop;
   logic wr_wrap;
   logic rd_wrap;

   // room left whenever the fill count is below the depth
   assign in_ready_o = (count_r != accel_map_pkg::rx_count_width_lp'(
                                      accel_map_pkg::rx_fifo_els_lp));
   assign head_v_o   = (count_r != '0);

   // oldest entry is always visible at the read pointer
   assign head_req_o = mem_r[rd_ptr_r];

   assign push = in_v_i & in_ready_o;
   // a pop on an empty queue is ignored
   assign pop  = pop_i & head_v_o;

   // pointers wrap at the last entry
   assign wr_wrap = (wr_ptr_r == accel_map_pkg::rx_ptr_width_lp'(
                                    accel_map_pkg::rx_fifo_els_lp - 1));
   assign rd_wrap = (rd_ptr_r == accel_map_pkg::rx_ptr_width_lp'(
                                    accel_map_pkg::rx_fifo_els_lp - 1));

   // payload storage written on accept
   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= in_req_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= wr_wrap ? '0 : wr_ptr_r + 1'b1;
         if (pop)
            rd_ptr_r <= rd_wrap ? '0 : rd_ptr_r + 1'b1;
         // fill count only moves when exactly one side fires
         case ({push, pop})
            2'b10:   count_r <= count_r + 1'b1;
            2'b01:   count_r <= count_r - 1'b1;
            default: count_r <= count_r;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- verilog/accel_tile.sv
`default_nettype none

module accel_tile
(
   input  logic                                      clk_i,
   input  logic                                      rst_n_i,

   // incoming remote writes
   input  logic                                      in_v_i,
   input  accel_net_pkg::rx_req_s                    in_req_i,
   output logic                                      in_ready_o,

   // outgoing store packets
   output logic                                      out_v_o,
   output accel_net_pkg::net_packet_s                out_packet_o,
   input  logic                                      out_ready_i,

   // one pulse per credit handed back by the network
   input  logic                                      link_credit_i,
   output logic [accel_map_pkg::credit_width_lp-1:0] out_credits_o,

   // position of this tile in the mesh
   input  logic [accel_net_pkg::x_cord_width_lp-1:0] my_x_i,
   input  logic [accel_net_pkg::y_cord_width_lp-1:0] my_y_i
);

   // queue head shared by the config and issue blocks
   logic                   head_v_lo;
   accel_net_pkg::rx_req_s head_req_lo;

   logic                   pop_lo;
   logic                   cfg_take_lo;
   accel_map_pkg::cfg_s    cfg_lo;
   logic                   sent_lo;

   // receive queue for remote writes
   accel_rx_fifo rx_fifo
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .in_v_i     (in_v_i),
      .in_req_i   (in_req_i),
      .in_ready_o (in_ready_o),
      .pop_i      (pop_lo),
      .head_v_o   (head_v_lo),
      .head_req_o (head_req_lo)
   );

   // addresses 0 and 1 land here
   accel_cfg_regs cfg_regs
   (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .head_v_i   (head_v_lo),
      .head_req_i (head_req_lo),
      .cfg_take_o (cfg_take_lo),
      .cfg_o      (cfg_lo)
   );

   // outstanding packet accounting
   accel_credit_counter credit_counter
   (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .sent_i          (sent_lo),
      .credit_return_i (link_credit_i),
      .credits_o       (out_credits_o)
   );

   // addresses 2 and 3, plus the single pop back to the queue
   accel_packet_issue packet_issue
   (
      .head_v_i     (head_v_lo),
      .head_req_i   (head_req_lo),
      .cfg_i        (cfg_lo),
      .cfg_take_i   (cfg_take_lo),
      .credits_i    (out_credits_o),
      .out_ready_i  (out_ready_i),
      .my_x_i       (my_x_i),
      .my_y_i       (my_y_i),
      .out_v_o      (out_v_o),
      .out_packet_o (out_packet_o),
      .sent_o       (sent_lo),
      .pop_o        (pop_lo)
   );

endmodule

`default_nettype wire
